// File: qspi_pkg.sv
`default_nettype none

package qspi_pkg;

  // one burst request from the user side.
  typedef struct packed {
    logic        write;  // 1 = write, 0 = read.
    logic [23:0] addr;   // start byte address.
    logic [7:0]  len;    // byte count, 0 means 256.
  } qspi_req_t;

  // what one agent puts on the four dio lines.
  typedef struct packed {
    logic [3:0] dout;
    logic [3:0] oe;
  } qspi_drv_t;

  // command opcodes, sent lsb first on dio[0].
  localparam logic [7:0] CMD_WRITE = 8'h38;
  localparam logic [7:0] CMD_READ  = 8'heb;

  // clocks per phase.
  localparam int unsigned CMD_CYCLES  = 8;
  localparam int unsigned ADDR_CYCLES = 6;

endpackage

`default_nettype wire

// File: psram.sv
`timescale 1ns/1ns
`default_nettype none

module psram import qspi_pkg::*; #(
  parameter int MEM_AW = 22
) (
  input logic sck,
  input logic ce_n,
  inout wire [3:0] dio
);

  localparam logic [1:0] ST_CMD   = 2'd0;
  localparam logic [1:0] ST_ADDR  = 2'd1;
  localparam logic [1:0] ST_WRITE = 2'd2;
  localparam logic [1:0] ST_READ  = 2'd3;

  localparam logic [2:0] CMD_LAST  = 3'(CMD_CYCLES - 1);
  localparam logic [2:0] ADDR_LAST = 3'(ADDR_CYCLES - 1);

  logic [7:0] mem [0:(1 << MEM_AW) - 1];

  logic [1:0]  state;
  logic [1:0]  next_state;
  logic [2:0]  cnt;
  logic [2:0]  cnt_lim;
  logic [7:0]  cmd;
  logic [23:0] addr;
  logic        cmd_ok;
  logic        parked;
  logic [MEM_AW-1:0] idx;
  qspi_drv_t   dev_drv;

  assign idx    = addr[MEM_AW-1:0];  // wraps modulo array size.
  assign cmd_ok = (cmd == CMD_WRITE) || (cmd == CMD_READ);

  // bad opcode holds here until ce_n rises.
  assign parked = (state == ST_ADDR) && (cnt == ADDR_LAST) && !cmd_ok;

  always_comb begin
    case (state)
      ST_CMD:  cnt_lim = CMD_LAST;
      ST_ADDR: cnt_lim = ADDR_LAST;
      default: cnt_lim = 3'd1;  // two nibbles per byte.
    endcase
  end

  always_ff @(posedge sck or posedge ce_n) begin
    if (ce_n) begin
      cnt <= '0;
    end else if (cnt == cnt_lim) begin
      cnt <= parked ? cnt : 3'd0;
    end else begin
      cnt <= cnt + 3'd1;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      ST_CMD: begin
        if (cnt == CMD_LAST) next_state = ST_ADDR;
      end
      ST_ADDR: begin
        if (cnt == ADDR_LAST) begin
          if (cmd == CMD_WRITE) next_state = ST_WRITE;
          else if (cmd == CMD_READ) next_state = ST_READ;
        end
      end
      default: ;  // bursts run until ce_n.
    endcase
  end

  always_ff @(posedge sck or posedge ce_n) begin
    if (ce_n) begin
      state <= ST_CMD;
      cmd   <= '0;
      addr  <= '0;
    end else begin
      state <= next_state;
      if (state == ST_CMD) cmd[cnt] <= dio[0];  // lsb first.
      if (state == ST_ADDR) begin
        addr <= {addr[19:0], dio};
      end else if (state == ST_WRITE || state == ST_READ) begin
        if (cnt == 3'd1) addr <= addr + 24'd1;
      end
    end
  end

  // byte array, high nibble on the first data clock.
  always_ff @(posedge sck) begin
    if (state == ST_WRITE) begin
      if (cnt == 3'd0) mem[idx][7:4] <= dio;
      else mem[idx][3:0] <= dio;
    end
  end

  always_comb begin
    dev_drv.dout = (cnt == 3'd0) ? mem[idx][7:4] : mem[idx][3:0];
    dev_drv.oe   = (state == ST_READ) ? 4'hf : 4'h0;
  end

  genvar i;
  generate
    for (i = 0; i < 4; i++) begin : g_dio
      assign dio[i] = dev_drv.oe[i] ? dev_drv.dout[i] : 1'bz;
    end
  endgenerate

  // the host only ever sends write or read.
  a_cmd_known: assert property (@(posedge sck) disable iff (ce_n)
    (state == ST_ADDR && cnt == ADDR_LAST) |-> cmd_ok)
    else $error("psram: unknown command %h", cmd);

  a_cnt_range: assert property (@(posedge sck) disable iff (ce_n)
    cnt <= cnt_lim)
    else $error("psram: cnt %0d past limit in state %0d", cnt, state);

endmodule

`default_nettype wire

// File: qspi_host.sv
`timescale 1ns/1ns
`default_nettype none

module qspi_host import qspi_pkg::*; (
  input  logic       sck,
  input  logic       ce_n,
  input  logic       req_valid,
  input  qspi_req_t  req,
  output logic       busy,
  output logic       wr_take,
  input  logic [7:0] wr_data,
  output logic       rd_valid,
  output logic [7:0] rd_data,
  output logic       mem_ce_n,
  output qspi_drv_t  host_drv,
  input  logic [3:0] dio_in
);

  localparam logic [2:0] H_IDLE = 3'd0;
  localparam logic [2:0] H_CMD  = 3'd1;
  localparam logic [2:0] H_ADDR = 3'd2;
  localparam logic [2:0] H_WR   = 3'd3;
  localparam logic [2:0] H_RD   = 3'd4;
  localparam logic [2:0] H_GAP  = 3'd5;

  localparam logic [2:0] CMD_LAST  = 3'(CMD_CYCLES - 1);
  localparam logic [2:0] ADDR_LAST = 3'(ADDR_CYCLES - 1);

  logic [2:0]  phase;
  logic [2:0]  cnt;      // tracks the device counter.
  logic [7:0]  rem;      // bytes left, 0 means 256.
  logic        wr_mode;
  logic        last_byte;
  logic        start;
  logic [7:0]  cmd;
  logic [23:0] addr_sr;
  logic [7:0]  wbyte;
  logic [3:0]  rd_hi;

  assign start     = (phase == H_IDLE) && req_valid;
  assign last_byte = (rem == 8'd1);
  assign busy      = (phase != H_IDLE);

  // next byte is fetched one cycle ahead of its high nibble.
  assign wr_take = wr_mode &&
                   ((phase == H_ADDR && cnt == ADDR_LAST) ||
                    (phase == H_WR && cnt == 3'd1 && !last_byte));

  always_ff @(posedge sck or posedge ce_n) begin
    if (ce_n) begin
      phase    <= H_IDLE;
      cnt      <= '0;
      rem      <= '0;
      wr_mode  <= 1'b0;
      mem_ce_n <= 1'b1;
    end else begin
      case (phase)
        H_IDLE: begin
          if (req_valid) begin
            phase    <= H_CMD;
            cnt      <= '0;
            rem      <= req.len;
            wr_mode  <= req.write;
            mem_ce_n <= 1'b0;  // bit 0 of the command goes out now.
          end
        end
        H_CMD: begin
          if (cnt == CMD_LAST) begin
            phase <= H_ADDR;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 3'd1;
          end
        end
        H_ADDR: begin
          if (cnt == ADDR_LAST) begin
            phase <= wr_mode ? H_WR : H_RD;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 3'd1;
          end
        end
        H_WR, H_RD: begin
          if (cnt == 3'd1) begin
            cnt <= '0;
            rem <= rem - 8'd1;
            if (last_byte) begin
              phase    <= H_GAP;
              mem_ce_n <= 1'b1;
            end
          end else begin
            cnt <= 3'd1;
          end
        end
        H_GAP:   phase <= H_IDLE;  // one idle clock with ce high.
        default: phase <= H_IDLE;
      endcase
    end
  end

  always_ff @(posedge sck) begin
    if (start) begin
      cmd     <= req.write ? CMD_WRITE : CMD_READ;
      addr_sr <= req.addr;
    end else if (phase == H_ADDR) begin
      addr_sr <= {addr_sr[19:0], 4'h0};  // msb nibble first.
    end
    if (wr_take) wbyte <= wr_data;
    if (phase == H_RD && cnt == 3'd0) rd_hi <= dio_in;
    if (phase == H_RD && cnt == 3'd1) rd_data <= {rd_hi, dio_in};
  end

  always_ff @(posedge sck or posedge ce_n) begin
    if (ce_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= (phase == H_RD) && (cnt == 3'd1);
    end
  end

  // bus drive. released for the whole read phase.
  always_comb begin
    host_drv = '0;
    case (phase)
      H_CMD: begin
        host_drv.dout = {3'b000, cmd[cnt]};
        host_drv.oe   = 4'b0001;
      end
      H_ADDR: begin
        host_drv.dout = addr_sr[23:20];
        host_drv.oe   = 4'hf;
      end
      H_WR: begin
        host_drv.dout = (cnt == 3'd0) ? wbyte[7:4] : wbyte[3:0];
        host_drv.oe   = 4'hf;
      end
      default: ;
    endcase
  end

  a_req_idle: assert property (@(posedge sck) disable iff (ce_n)
    req_valid |-> !busy)
    else $error("qspi_host: request while busy");

  a_oe_framed: assert property (@(posedge sck) disable iff (ce_n)
    mem_ce_n |-> (host_drv.oe == 4'h0))
    else $error("qspi_host: bus driven outside frame");

endmodule

`default_nettype wire

// File: psram_sys_top.sv
`timescale 1ns/1ns
`default_nettype none

module psram_sys_top import qspi_pkg::*; #(
  parameter int MEM_AW = 22
) (
  input  logic       sck,
  input  logic       ce_n,
  input  logic       req_valid,
  input  qspi_req_t  req,
  output logic       busy,
  output logic       wr_take,
  input  logic [7:0] wr_data,
  output logic       rd_valid,
  output logic [7:0] rd_data
);

  wire [3:0] dio;  // shared quad bus.
  wire [3:0] dio_in;
  wire       mem_ce_n;
  qspi_drv_t host_drv;

  qspi_host host_i (
    .sck       (sck),
    .ce_n      (ce_n),
    .req_valid (req_valid),
    .req       (req),
    .busy      (busy),
    .wr_take   (wr_take),
    .wr_data   (wr_data),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .mem_ce_n  (mem_ce_n),
    .host_drv  (host_drv),
    .dio_in    (dio_in)
  );

  psram #(.MEM_AW(MEM_AW)) mem_i (
    .sck  (sck),
    .ce_n (mem_ce_n),
    .dio  (dio)
  );

  genvar i;
  generate
    for (i = 0; i < 4; i++) begin : g_host_dio
      assign dio[i] = host_drv.oe[i] ? host_drv.dout[i] : 1'bz;
    end
  endgenerate

  assign dio_in = dio;

endmodule

`default_nettype wire

// File: tb_psram_sys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_psram_sys import qspi_pkg::*; ();

  localparam int TB_AW = 10;

  logic       sck;
  logic       ce_n;
  logic       req_valid;
  qspi_req_t  req;
  logic       busy;
  logic       wr_take;
  logic [7:0] wr_data;
  logic       rd_valid;
  logic [7:0] rd_data;

  logic [7:0]       model [0:(1 << TB_AW) - 1];  // reference memory.
  logic [TB_AW-1:0] wr_ptr;
  logic [TB_AW-1:0] rd_ptr;
  logic [7:0]       exp_rd;
  logic [15:0]      lfsr;
  logic             started;
  int busy_cycles;
  int take_cnt;
  int valid_cnt;
  int exp_cycles;
  int exp_takes;
  int exp_valids;
  int val_errs;
  int cnt_errs;
  int timeouts;

  psram_sys_top #(.MEM_AW(TB_AW)) dut_i (
    .sck       (sck),
    .ce_n      (ce_n),
    .req_valid (req_valid),
    .req       (req),
    .busy      (busy),
    .wr_take   (wr_take),
    .wr_data   (wr_data),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  always #20 sck = ~sck;

  // right shifting form of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [23:0] take_bits(input int n);
    logic [23:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[22:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // write source and strobe counters.
  always @(negedge sck) begin
    if (busy) busy_cycles++;
    if (wr_take) begin
      take_cnt++;
      wr_data = 8'(take_bits(8));
      model[wr_ptr] = wr_data;
      wr_ptr++;  // wraps like the device.
    end
    if (rd_valid) begin
      valid_cnt++;
      exp_rd = model[rd_ptr];
      rd_ptr++;
    end
  end

  a_idle_at_start: assert property (@(posedge sck) disable iff (ce_n)
    !started |-> (!busy && !wr_take && !rd_valid))
    else begin
      val_errs++;
      $display("Error: busy/wr_take/rd_valid expected 0 0 0 got %h %h %h",
               $sampled(busy), $sampled(wr_take), $sampled(rd_valid));
    end

  a_req_starts: assert property (@(posedge sck) disable iff (ce_n)
    req_valid |=> busy)
    else begin
      val_errs++;
      $display("Error: busy expected %h got %h", 1'b1, $sampled(busy));
    end

  a_rd_byte: assert property (@(posedge sck) disable iff (ce_n)
    rd_valid |-> (rd_data == exp_rd))
    else begin
      val_errs++;
      $display("Error: rd_data expected %h got %h", $sampled(exp_rd), $sampled(rd_data));
    end

  a_frame_len: assert property (@(posedge sck) disable iff (ce_n)
    $fell(busy) |-> (busy_cycles == exp_cycles))
    else begin
      cnt_errs++;
      $display("Error: busy cycles expected %h got %h", exp_cycles, busy_cycles);
    end

  a_take_count: assert property (@(posedge sck) disable iff (ce_n)
    $fell(busy) |-> (take_cnt == exp_takes))
    else begin
      cnt_errs++;
      $display("Error: wr_take pulses expected %h got %h", exp_takes, take_cnt);
    end

  a_valid_count: assert property (@(posedge sck) disable iff (ce_n)
    $fell(busy) |-> (valid_cnt == exp_valids))
    else begin
      cnt_errs++;
      $display("Error: rd_valid pulses expected %h got %h", exp_valids, valid_cnt);
    end

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < 2000) begin
      @(negedge sck);
      n++;
    end
    if (busy) begin
      timeouts++;
      $display("Timeout: busy still high after 2000 cycles");
    end
  endtask

  // one request and a wait for the frame to end.
  task automatic run_burst(input logic wr, input logic [23:0] addr, input logic [7:0] len);
    int nb;
    nb = (len == 8'd0) ? 256 : int'(len);
    @(negedge sck);
    req = '{write: wr, addr: addr, len: len};
    req_valid = 1'b1;
    started = 1'b1;
    busy_cycles = 0;
    take_cnt = 0;
    valid_cnt = 0;
    exp_cycles = 15 + 2 * nb;
    exp_takes = wr ? nb : 0;
    exp_valids = wr ? 0 : nb;
    wr_ptr = addr[TB_AW-1:0];
    rd_ptr = addr[TB_AW-1:0];
    @(negedge sck);
    req_valid = 1'b0;
    wait_idle();
  endtask

  initial begin
    logic [23:0] a;
    logic [7:0]  n;
    sck = 1'b0;
    ce_n = 1'b1;
    req_valid = 1'b0;
    req = '0;
    wr_data = '0;
    lfsr = 16'd19;
    started = 1'b0;
    val_errs = 0;
    cnt_errs = 0;
    timeouts = 0;
    repeat (10) @(negedge sck);
    ce_n = 1'b0;
    repeat (4) @(negedge sck);

    repeat (4) begin
      a = take_bits(24);
      n = 8'(take_bits(6)) + 8'd1;
      run_burst(1'b1, a, n);
      run_burst(1'b0, a, n);
    end

    a = take_bits(24);  // len 0 is a full 256 byte burst.
    run_burst(1'b1, a, 8'd0);
    run_burst(1'b0, a, 8'd0);

    // runs past the top of the array into address 0.
    a = {14'(take_bits(14)), 10'h3fd};
    run_burst(1'b1, a, 8'd8);
    run_burst(1'b0, 24'h0, 8'd5);

    // later write wins where the two overlap.
    a = 24'(take_bits(10));
    run_burst(1'b1, a, 8'd12);
    run_burst(1'b1, a + 24'd5, 8'd12);
    run_burst(1'b0, a, 8'd17);

    repeat (4) @(negedge sck);
    $display("errors: value %0d, count %0d, timeout %0d", val_errs, cnt_errs, timeouts);
    if (val_errs + cnt_errs + timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
qspi_pkg.sv
psram.sv
qspi_host.sv
psram_sys_top.sv
tb_psram_sys.sv

// File: Bender.yml
package:
  name: psram_sys

sources:
  - qspi_pkg.sv
  - psram.sv
  - qspi_host.sv
  - psram_sys_top.sv
  - target: test
    files:
      - tb_psram_sys.sv
